// ==== lsu_iq_top.f ====
rtl/lsu_pkg.sv
rtl/iq_entry.sv
rtl/iq_ptr_ctrl.sv
rtl/lsu_issue_fsm.sv
rtl/lsu_agu.sv
rtl/lsu_dmem.sv
rtl/lsu_iq_top.sv
tb/tb_clkgen.sv
tb/lsu_iq_tb.sv

// ==== rtl/iq_entry.sv ====
`timescale 1ns/1ns

module iq_entry #(
    parameter int CDB_COUNT = 2
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          flush_i,
    input  logic                          init_i,
    input  lsu_pkg::dispatch_t            op_i,
    input  logic                          select_i,
    input  lsu_pkg::cdb_t [CDB_COUNT-1:0] cdb_i,
    output logic                          valid_o,
    output logic                          ready_o,
    output lsu_pkg::dispatch_t            op_o
);
    import lsu_pkg::*;

    dispatch_t op_q;
    dispatch_t op_next;
    logic      valid_q;

    // --------------------------------------------------
    // operand wakeup
    // --------------------------------------------------
    // incoming op is compared too, so a broadcast in the
    // dispatch cycle is not missed
    always_comb begin
        op_next = init_i ? op_i : op_q;
        for (int s = 0; s < 2; s++) begin
            for (int c = 0; c < CDB_COUNT; c++) begin
                if (!op_next.src[s].ready && cdb_i[c].valid &&
                    (cdb_i[c].tag == op_next.src[s].tag)) begin
                    op_next.src[s].data  = cdb_i[c].data;
                    op_next.src[s].ready = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        op_q <= op_next;
    end

    // --------------------------------------------------
    // occupancy
    // --------------------------------------------------
    // a fresh load wins over a stale select
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (init_i) begin
            valid_q <= 1'b1;
        end else if (select_i) begin
            valid_q <= 1'b0;
        end
    end

    assign valid_o = valid_q;
    assign ready_o = valid_q && op_q.src[0].ready && op_q.src[1].ready;
    assign op_o    = op_q;

endmodule

// ==== rtl/iq_ptr_ctrl.sv ====
`timescale 1ns/1ns

module iq_ptr_ctrl #(
    parameter int IQ_SIZE = 8
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       flush_i,
    input  logic [1:0]                 push_count_i,
    input  logic                       pop_i,
    output logic [$clog2(IQ_SIZE)-1:0] head_o,
    output logic [$clog2(IQ_SIZE)-1:0] tail_o,
    output logic                       entry_ready_o
);
    localparam int PTR_W = $clog2(IQ_SIZE);
    localparam int CNT_W = PTR_W + 1;

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] free_q;
    logic [CNT_W-1:0] free_next;

    // pops free an entry, pushes take one or two
    assign free_next = free_q - CNT_W'(push_count_i) + CNT_W'(pop_i);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            head_q        <= '0;
            tail_q        <= '0;
            free_q        <= CNT_W'(IQ_SIZE);
            entry_ready_o <= 1'b1;
        end else begin
            // pointers wrap on their own width
            head_q        <= head_q + PTR_W'(pop_i);
            tail_q        <= tail_q + PTR_W'(push_count_i);
            free_q        <= free_next;
            // room for a full dual dispatch next cycle
            entry_ready_o <= (free_next >= CNT_W'(2));
        end
    end

    assign head_o = head_q;
    assign tail_o = tail_q;

endmodule

// ==== rtl/lsu_agu.sv ====
`timescale 1ns/1ns

module lsu_agu (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               flush_i,
    input  logic               load_i,
    input  lsu_pkg::dispatch_t op_i,
    output lsu_pkg::mem_req_t  req_o
);
    import lsu_pkg::*;

    dispatch_t  op_q;
    word_t      addr;
    logic [3:0] size_mask;
    logic [3:0] lane_mask;
    logic       is_store;

    // issue register
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            op_q <= '0;
        end else if (load_i) begin
            op_q <= op_i;
        end
    end

    // --------------------------------------------------
    // address and lanes
    // --------------------------------------------------
    always_comb begin
        addr = op_q.src[1].data + {{(XLEN-12){op_q.imm[11]}}, op_q.imm};

        case (op_q.op)
            OP_LB, OP_LBU, OP_SB: size_mask = 4'b0001;
            OP_LH, OP_LHU, OP_SH: size_mask = 4'b0011;
            default:              size_mask = 4'b1111;
        endcase

        is_store  = op_q.op inside {OP_SB, OP_SH, OP_SW};
        lane_mask = size_mask << addr[1:0];

        req_o.op     = op_q.op;
        req_o.addr   = addr;
        // store data moves into its byte lanes
        req_o.wdata  = op_q.src[0].data << {addr[1:0], 3'b000};
        req_o.strb   = is_store ? lane_mask : 4'b0000;
        req_o.rmask  = is_store ? 4'b0000 : lane_mask;
        req_o.rob_id = op_q.rob_id;
    end

endmodule

// ==== rtl/lsu_dmem.sv ====
`timescale 1ns/1ns

module lsu_dmem #(
    parameter int DMEM_WORDS = 64
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              flush_i,
    input  logic              req_valid_i,
    input  lsu_pkg::mem_req_t req_i,
    output logic              req_ready_o,
    input  logic              result_ready_i,
    output logic              result_valid_o,
    output lsu_pkg::result_t  result_o
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);

    word_t            mem [DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             accept;
    logic             is_store;
    word_t            lane_word;
    word_t            shifted;
    word_t            load_data;
    logic             resp_valid_q;
    result_t          resp_q;

    // word index wraps over the array
    assign idx         = req_i.addr[IDX_W+1:2];
    assign req_ready_o = !resp_valid_q || result_ready_i;
    assign accept      = req_valid_i && req_ready_o && !flush_i;
    assign is_store    = req_i.op inside {OP_SB, OP_SH, OP_SW};

    // byte-strobe write
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.strb[b]) begin
                    mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // --------------------------------------------------
    // load extraction
    // --------------------------------------------------
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            lane_word[8*b +: 8] = req_i.rmask[b] ? mem[idx][8*b +: 8] : 8'h00;
        end
        shifted = lane_word >> {req_i.addr[1:0], 3'b000};
        case (req_i.op)
            OP_LB:   load_data = {{24{shifted[7]}}, shifted[7:0]};
            OP_LBU:  load_data = {24'h000000, shifted[7:0]};
            OP_LH:   load_data = {{16{shifted[15]}}, shifted[15:0]};
            OP_LHU:  load_data = {16'h0000, shifted[15:0]};
            default: load_data = shifted;
        endcase
    end

    // --------------------------------------------------
    // response register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            resp_valid_q <= 1'b0;
        end else if (accept) begin
            resp_valid_q <= 1'b1;
        end else if (result_ready_i) begin
            resp_valid_q <= 1'b0;
        end
    end

    // stores answer with zero data
    always_ff @(posedge clk) begin
        if (accept) begin
            resp_q.rob_id   <= req_i.rob_id;
            resp_q.data     <= is_store ? '0 : load_data;
            resp_q.is_store <= is_store;
        end
    end

    assign result_valid_o = resp_valid_q;
    assign result_o       = resp_q;

endmodule

// ==== rtl/lsu_iq_top.sv ====
`timescale 1ns/1ns

module lsu_iq_top #(
    parameter int IQ_SIZE    = 8,
    parameter int CDB_COUNT  = 2,
    parameter int DMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          flush_i,
    input  logic [1:0]                    choose_i,
    input  lsu_pkg::dispatch_t [1:0]      dispatch_i,
    output logic                          entry_ready_o,
    input  lsu_pkg::cdb_t [CDB_COUNT-1:0] cdb_i,
    input  logic                          result_ready_i,
    output logic                          result_valid_o,
    output lsu_pkg::result_t              result_o
);
    import lsu_pkg::*;

    localparam int PTR_W = $clog2(IQ_SIZE);

    logic [PTR_W-1:0]        head;
    logic [PTR_W-1:0]        tail;
    logic [PTR_W-1:0]        tail_next;
    logic [1:0]              push_count;
    logic [IQ_SIZE-1:0]      entry_init;
    logic [IQ_SIZE-1:0]      entry_select;
    logic [IQ_SIZE-1:0]      entry_valid;
    logic [IQ_SIZE-1:0]      entry_ready;
    dispatch_t [IQ_SIZE-1:0] entry_in;
    dispatch_t [IQ_SIZE-1:0] entry_op;
    dispatch_t               head_op;
    logic                    head_ready;
    logic                    pop;
    logic                    req_valid;
    logic                    req_ready;
    mem_req_t                req;

    // --------------------------------------------------
    // dispatch steering
    // --------------------------------------------------
    assign tail_next  = tail + PTR_W'(1);
    assign push_count = entry_ready_o ? ({1'b0, choose_i[0]} + {1'b0, choose_i[1]}) : 2'd0;

    // single op always lands on the tail, a pair fills tail and tail+1
    always_comb begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            entry_init[i] = 1'b0;
            entry_in[i]   = dispatch_i[0];
            if (entry_ready_o && (PTR_W'(i) == tail) && (|choose_i)) begin
                entry_init[i] = 1'b1;
                entry_in[i]   = choose_i[0] ? dispatch_i[0] : dispatch_i[1];
            end else if (entry_ready_o && (PTR_W'(i) == tail_next) && (&choose_i)) begin
                entry_init[i] = 1'b1;
                entry_in[i]   = dispatch_i[1];
            end
        end
    end

    // --------------------------------------------------
    // entry array
    // --------------------------------------------------
    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        assign entry_select[i] = pop && (PTR_W'(i) == head);

        iq_entry #(
            .CDB_COUNT(CDB_COUNT)
        ) iq_entry_inst (
            .clk      (clk),
            .reset_i  (reset_i),
            .flush_i  (flush_i),
            .init_i   (entry_init[i]),
            .op_i     (entry_in[i]),
            .select_i (entry_select[i]),
            .cdb_i    (cdb_i),
            .valid_o  (entry_valid[i]),
            .ready_o  (entry_ready[i]),
            .op_o     (entry_op[i])
        );
    end

    // in-order issue, only the head is looked at
    assign head_op    = entry_op[head];
    assign head_ready = entry_valid[head] && entry_ready[head];

    iq_ptr_ctrl #(
        .IQ_SIZE(IQ_SIZE)
    ) iq_ptr_ctrl_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .push_count_i  (push_count),
        .pop_i         (pop),
        .head_o        (head),
        .tail_o        (tail),
        .entry_ready_o (entry_ready_o)
    );

    // --------------------------------------------------
    // issue slot and memory
    // --------------------------------------------------
    lsu_issue_fsm lsu_issue_fsm_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .head_ready_i (head_ready),
        .req_ready_i  (req_ready),
        .pop_o        (pop),
        .req_valid_o  (req_valid)
    );

    lsu_agu lsu_agu_inst (
        .clk     (clk),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .load_i  (pop),
        .op_i    (head_op),
        .req_o   (req)
    );

    lsu_dmem #(
        .DMEM_WORDS(DMEM_WORDS)
    ) lsu_dmem_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .req_valid_i    (req_valid),
        .req_i          (req),
        .req_ready_o    (req_ready),
        .result_ready_i (result_ready_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

endmodule

// ==== rtl/lsu_issue_fsm.sv ====
`timescale 1ns/1ns

module lsu_issue_fsm (
    input  logic clk,
    input  logic reset_i,
    input  logic flush_i,
    input  logic head_ready_i,
    input  logic req_ready_i,
    output logic pop_o,
    output logic req_valid_o
);
    import lsu_pkg::*;

    issue_state_e state_q;
    issue_state_e state_next;
    logic         take;

    // slot can take a new op when empty or when the
    // held request leaves this cycle
    assign take  = (state_q == ISS_IDLE) || req_ready_i;
    assign pop_o = take && head_ready_i;

    always_comb begin
        state_next = state_q;
        if (take) begin
            state_next = head_ready_i ? ISS_HELD : ISS_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            state_q <= ISS_IDLE;
        end else begin
            state_q <= state_next;
        end
    end

    // held means a request sits in the AGU register
    assign req_valid_o = (state_q == ISS_HELD);

endmodule

// ==== rtl/lsu_pkg.sv ====
package lsu_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int XLEN     = 32;
    localparam int ROB_ID_W = 6;

    typedef logic [ROB_ID_W-1:0] rob_id_t;
    typedef logic [XLEN-1:0]     word_t;

    // --------------------------------------------------
    // encodings
    // --------------------------------------------------
    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LH  = 3'd1,
        OP_LW  = 3'd2,
        OP_LBU = 3'd3,
        OP_LHU = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } mem_op_e;

    typedef enum logic {
        ISS_IDLE = 1'b0,
        ISS_HELD = 1'b1
    } issue_state_e;

    // --------------------------------------------------
    // bundles
    // --------------------------------------------------
    // one source operand
    typedef struct packed {
        word_t   data;
        rob_id_t tag;
        logic    ready;
    } src_t;

    // src[0] is store data, src[1] is the base address
    typedef struct packed {
        mem_op_e            op;
        logic signed [11:0] imm;
        rob_id_t            rob_id;
        src_t [1:0]         src;
    } dispatch_t;

    typedef struct packed {
        mem_op_e    op;
        word_t      addr;
        word_t      wdata;
        logic [3:0] strb;
        logic [3:0] rmask;
        rob_id_t    rob_id;
    } mem_req_t;

    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   data;
    } cdb_t;

    typedef struct packed {
        rob_id_t rob_id;
        word_t   data;
        logic    is_store;
    } result_t;

endpackage

// ==== tb/lsu_iq_tb.sv ====
`timescale 1ns/1ns

module lsu_iq_tb;
    import lsu_pkg::*;

    localparam int          IQ_SIZE    = 8;
    localparam int          CDB_COUNT  = 2;
    localparam int          DMEM_WORDS = 64;
    localparam int          N_STORES   = 16;
    localparam int          N_LOADS    = 25;
    localparam int          N_PAIRS    = 24;
    localparam int          N_WAKE     = 12;
    localparam int          N_BATCHES  = 24;
    localparam int          TOTAL_OPS  = DMEM_WORDS + N_STORES + N_LOADS + 2 * N_PAIRS
                                         + N_WAKE + 2 * N_BATCHES + 2 * IQ_SIZE + 8;
    localparam logic [31:0] SEED       = 32'hf64ee7f4;
    localparam rob_id_t     FULL_TAG   = 6'h3e;
    localparam rob_id_t     STUCK_TAG  = 6'h3f;
    localparam word_t       FULL_BASE  = 32'h0000_0080;

    logic                 clk;
    logic                 reset_i;
    logic                 flush_i;
    logic [1:0]           choose_i;
    dispatch_t [1:0]      dispatch_i;
    logic                 entry_ready_o;
    cdb_t [CDB_COUNT-1:0] cdb_i;
    logic                 result_ready_i;
    logic                 result_valid_o;
    result_t              result_o;

    // byte model of the 256-byte data memory
    logic [7:0]  model_mem [256];
    logic        tag_seen [2**ROB_ID_W];
    result_t     exp_q [$];
    int          wait_q [$];
    string       name_q [$];
    string       test_name;
    logic [31:0] rng_state;
    logic [31:0] stall_state;
    logic        stall_en;
    logic        ready_hold;
    rob_id_t     next_rob;

    tb_clkgen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (10)
    ) tb_clkgen_inst (
        .clk     (clk),
        .reset_o (reset_i)
    );

    lsu_iq_top #(
        .IQ_SIZE    (IQ_SIZE),
        .CDB_COUNT  (CDB_COUNT),
        .DMEM_WORDS (DMEM_WORDS)
    ) lsu_iq_top_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .choose_i       (choose_i),
        .dispatch_i     (dispatch_i),
        .entry_ready_o  (entry_ready_o),
        .cdb_i          (cdb_i),
        .result_ready_i (result_ready_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    // --------------------------------------------------
    // random numbers and operation builders
    // --------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_next();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic mem_op_e random_kind();
        logic [31:0] r;
        r = rand_next();
        return mem_op_e'(r[2:0]);
    endfunction

    // multiple of four keeps any access aligned
    function automatic logic signed [11:0] random_imm();
        logic [31:0] r;
        r = rand_next();
        return {{4{r[13]}}, r[13:8], 2'b00};
    endfunction

    function automatic word_t fill_word(input word_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
    endfunction

    function automatic dispatch_t make_op(input mem_op_e kind, input word_t base,
                                          input logic signed [11:0] imm, input word_t data);
        dispatch_t d;
        d              = '0;
        d.op           = kind;
        d.imm          = imm;
        d.rob_id       = next_rob;
        d.src[0].data  = data;
        d.src[0].ready = 1'b1;
        d.src[1].data  = base;
        d.src[1].ready = 1'b1;
        next_rob       = next_rob + 1'b1;
        return d;
    endfunction

    function automatic dispatch_t random_op_of(input mem_op_e kind);
        logic [31:0]        r;
        word_t              addr;
        logic signed [11:0] imm;
        r    = rand_next();
        addr = {24'h0, r[7:0]};
        if (kind inside {OP_LH, OP_LHU, OP_SH}) begin
            addr[0] = 1'b0;
        end else if (kind inside {OP_LW, OP_SW}) begin
            addr[1:0] = 2'b00;
        end
        imm = random_imm();
        return make_op(kind, addr - {{20{imm[11]}}, imm}, imm, rand_next());
    endfunction

    // operand waits for a CDB tag instead of carrying its data
    function automatic dispatch_t hide_operand(input dispatch_t d, input int idx,
                                               input rob_id_t tag);
        dispatch_t h;
        h = d;
        if (idx == 0) begin
            h.src[0].data  = 32'hdead_beef;
            h.src[0].tag   = tag;
            h.src[0].ready = 1'b0;
        end else begin
            h.src[1].data  = 32'hdead_beef;
            h.src[1].tag   = tag;
            h.src[1].ready = 1'b0;
        end
        return h;
    endfunction

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic result_t apply_ref(input dispatch_t d);
        word_t      ea;
        logic [7:0] a;
        word_t      w;
        word_t      sd;
        result_t    r;
        ea         = d.src[1].data + {{20{d.imm[11]}}, d.imm};
        a          = ea[7:0];
        sd         = d.src[0].data;
        w          = {model_mem[a + 8'd3], model_mem[a + 8'd2],
                      model_mem[a + 8'd1], model_mem[a]};
        r.rob_id   = d.rob_id;
        r.data     = '0;
        r.is_store = 1'b0;
        case (d.op)
            OP_LB:  r.data = {{24{w[7]}}, w[7:0]};
            OP_LBU: r.data = {24'h000000, w[7:0]};
            OP_LH:  r.data = {{16{w[15]}}, w[15:0]};
            OP_LHU: r.data = {16'h0000, w[15:0]};
            OP_LW:  r.data = w;
            default: begin
                r.is_store   = 1'b1;
                model_mem[a] = sd[7:0];
                if (d.op != OP_SB) begin
                    model_mem[a + 8'd1] = sd[15:8];
                end
                if (d.op == OP_SW) begin
                    model_mem[a + 8'd2] = sd[23:16];
                    model_mem[a + 8'd3] = sd[31:24];
                end
            end
        endcase
        return r;
    endfunction

    // call in dispatch order so the model sees program order
    function automatic void record(input dispatch_t d, input int wait_tag);
        exp_q.push_back(apply_ref(d));
        wait_q.push_back(wait_tag);
        name_q.push_back(test_name);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // --------------------------------------------------
    // drivers called on a falling edge
    // --------------------------------------------------
    task automatic dispatch_ops(input dispatch_t d0, input dispatch_t d1,
                                input logic [1:0] ch, input cdb_t wake);
        while (!entry_ready_o) begin
            @(negedge clk);
        end
        dispatch_i[0] = d0;
        dispatch_i[1] = d1;
        choose_i      = ch;
        cdb_i[0]      = wake;
        if (wake.valid) begin
            tag_seen[wake.tag] = 1'b1;
        end
        @(negedge clk);
        choose_i = 2'b00;
        cdb_i[0] = '0;
    endtask

    task automatic broadcast(input int lane, input rob_id_t tag, input word_t data);
        cdb_i[lane].valid = 1'b1;
        cdb_i[lane].tag   = tag;
        cdb_i[lane].data  = data;
        tag_seen[tag]     = 1'b1;
        @(negedge clk);
        cdb_i[lane] = '0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic fill_memory();
        dispatch_t d0;
        dispatch_t d1;
        word_t     a;
        int        w;
        test_name = "mem_fill";
        for (w = 0; w < DMEM_WORDS; w += 2) begin
            a  = word_t'(4 * w);
            d0 = make_op(OP_SW, a, 12'sd0, fill_word(a));
            d1 = make_op(OP_SW, a + 32'd4, 12'sd0, fill_word(a + 32'd4));
            record(d0, -1);
            record(d1, -1);
            dispatch_ops(d0, d1, 2'b11, '0);
        end
        wait_drain();
    endtask

    task automatic store_then_load();
        dispatch_t   d;
        logic [31:0] r;
        mem_op_e     kind;
        int          i;
        test_name = "store_load";
        for (i = 0; i < N_STORES; i++) begin
            r    = rand_next();
            kind = (r[1:0] == 2'd0) ? OP_SB : (r[1:0] == 2'd1) ? OP_SH : OP_SW;
            d    = random_op_of(kind);
            record(d, -1);
            dispatch_ops(d, d, 2'b01, '0);
        end
        // every load size and signedness in turn
        for (i = 0; i < N_LOADS; i++) begin
            d = random_op_of(mem_op_e'(3'(i % 5)));
            record(d, -1);
            dispatch_ops(d, d, 2'b01, '0);
        end
        wait_drain();
    endtask

    task automatic dual_dispatch();
        dispatch_t d0;
        dispatch_t d1;
        int        i;
        test_name = "dual_dispatch";
        for (i = 0; i < N_PAIRS; i++) begin
            d0 = random_op_of(random_kind());
            d1 = random_op_of(random_kind());
            record(d0, -1);
            record(d1, -1);
            dispatch_ops(d0, d1, 2'b11, '0);
        end
        wait_drain();
    endtask

    task automatic cdb_wakeup();
        dispatch_t d;
        dispatch_t h;
        dispatch_t late_d [$];
        int        late_k [$];
        cdb_t      wake;
        int        b;
        int        i;
        int        k;
        test_name = "cdb_wakeup";
        for (b = 0; b < N_WAKE / 6; b++) begin
            for (i = 0; i < 6; i++) begin
                k = 6 * b + i;
                d = random_op_of(random_kind());
                h = hide_operand(d, k % 2, rob_id_t'(k + 1));
                record(d, k + 1);
                if (k % 3 == 0) begin
                    // tag arrives on the CDB in the dispatch cycle
                    wake.valid = 1'b1;
                    wake.tag   = rob_id_t'(k + 1);
                    wake.data  = (k % 2 == 0) ? d.src[0].data : d.src[1].data;
                    dispatch_ops(h, h, 2'b01, wake);
                end else begin
                    dispatch_ops(h, h, 2'b01, '0);
                    late_d.push_back(d);
                    late_k.push_back(k);
                end
            end
            repeat (4) @(negedge clk);
            // broadcast newest first so the head waits longest
            while (late_d.size() != 0) begin
                d = late_d.pop_back();
                k = late_k.pop_back();
                broadcast(late_d.size() % 2, rob_id_t'(k + 1),
                          (k % 2 == 0) ? d.src[0].data : d.src[1].data);
            end
            wait_drain();
        end
    endtask

    task automatic result_backpressure();
        dispatch_t   d0;
        dispatch_t   d1;
        logic [31:0] r;
        logic [1:0]  ch;
        int          i;
        test_name = "backpressure";
        stall_en  = 1'b1;
        for (i = 0; i < N_BATCHES; i++) begin
            r  = rand_next();
            ch = (r[1:0] == 2'b00) ? 2'b11 : r[1:0];
            d0 = random_op_of(random_kind());
            d1 = random_op_of(random_kind());
            if (ch[0]) begin
                record(d0, -1);
            end
            if (ch[1]) begin
                record(d1, -1);
            end
            dispatch_ops(d0, d1, ch, '0);
        end
        wait_drain();
        stall_en = 1'b0;
    endtask

    task automatic fill_queue();
        dispatch_t          d;
        mem_op_e            kind;
        logic signed [11:0] imm;
        word_t              data;
        int                 inflight;
        test_name = "full_queue";
        inflight  = 0;
        while (entry_ready_o && inflight < IQ_SIZE) begin
            kind = random_kind();
            imm  = random_imm();
            data = rand_next();
            d    = make_op(kind, FULL_BASE, imm, data);
            record(d, FULL_TAG);
            dispatch_ops(hide_operand(d, 1, FULL_TAG), d, 2'b01, '0);
            inflight++;
            assert (inflight <= IQ_SIZE - 1) else
                abort_run("entry_ready_o stayed high with every queue entry in use");
        end
        assert (!entry_ready_o) else
            abort_run("entry_ready_o never dropped while the queue filled");
        repeat (3) @(negedge clk);
        broadcast(1, FULL_TAG, FULL_BASE);
        wait_drain();
        assert (entry_ready_o) else
            abort_run("entry_ready_o did not return high after the queue drained");
    endtask

    task automatic flush_pending();
        dispatch_t   d;
        logic [31:0] r;
        word_t       addr [3];
        int          i;
        test_name = "flush";
        for (i = 0; i < 3; i++) begin
            r       = rand_next();
            addr[i] = {24'h0, r[7:2], 2'b00};
            d       = make_op(OP_SW, addr[i], 12'sd0, rand_next());
            record(d, -1);
            dispatch_ops(d, d, 2'b01, '0);
        end
        wait_drain();
        // response register and issue slot stay occupied
        ready_hold = 1'b1;
        @(negedge clk);
        for (i = 0; i < 2; i++) begin
            d = random_op_of(OP_LW);
            dispatch_ops(d, d, 2'b01, '0);
        end
        // the rest wait on a tag that arrives only after the flush
        while (entry_ready_o) begin
            d = random_op_of(random_kind());
            dispatch_ops(hide_operand(d, 1, STUCK_TAG), d, 2'b01, '0);
        end
        assert (!entry_ready_o && result_valid_o) else
            abort_run("queue and response register were not occupied before the flush");
        flush_i = 1'b1;
        @(negedge clk);
        flush_i    = 1'b0;
        ready_hold = 1'b0;
        // a stale entry would issue once its tag shows up
        broadcast(0, STUCK_TAG, 32'h0);
        repeat (10) @(negedge clk);
        assert (entry_ready_o && !result_valid_o) else
            abort_run("queue and response register not empty after flush");
        for (i = 0; i < 3; i++) begin
            d = make_op(OP_LW, addr[i], 12'sd0, 32'h0);
            record(d, -1);
            dispatch_ops(d, d, 2'b01, '0);
        end
        wait_drain();
    endtask

    // --------------------------------------------------
    // result checking
    // --------------------------------------------------
    always @(posedge clk) begin : compare_results
        result_t want;
        int      wtag;
        string   name;
        if (!reset_i && result_valid_o && result_ready_i) begin
            assert (exp_q.size() != 0) else
                abort_run($sformatf("result for rob_id %0d arrived with nothing pending",
                                    result_o.rob_id));
            want = exp_q.pop_front();
            wtag = wait_q.pop_front();
            name = name_q.pop_front();
            assert (wtag < 0 || tag_seen[wtag]) else
                abort_run($sformatf("result for rob_id %0d came before its CDB broadcast",
                                    result_o.rob_id));
            assert (result_o === want) else
                abort_run($sformatf("ERR %s expected %h actual %h", name, want, result_o));
        end
    end

    // random result_ready_i low periods
    always @(negedge clk) begin
        if (ready_hold) begin
            result_ready_i = 1'b0;
        end else if (stall_en) begin
            stall_state    = xorshift(stall_state);
            result_ready_i = (stall_state[1:0] != 2'b00);
        end else begin
            result_ready_i = 1'b1;
        end
    end

    initial begin : watchdog
        repeat (TOTAL_OPS * 40 + 200) @(posedge clk);
        abort_run("watchdog expired, results stopped arriving");
    end

    initial begin : stimulus
        int t;
        flush_i        = 1'b0;
        choose_i       = 2'b00;
        dispatch_i     = '0;
        cdb_i          = '0;
        result_ready_i = 1'b1;
        stall_en       = 1'b0;
        ready_hold     = 1'b0;
        rng_state      = SEED;
        stall_state    = ~SEED;
        next_rob       = '0;
        for (t = 0; t < 2**ROB_ID_W; t++) begin
            tag_seen[t] = 1'b0;
        end
        @(negedge clk);
        while (reset_i !== 1'b0) begin
            @(negedge clk);
        end
        assert (entry_ready_o === 1'b1 && result_valid_o === 1'b0) else
            abort_run("DUT not idle after reset");
        fill_memory();
        store_then_load();
        dual_dispatch();
        cdb_wakeup();
        result_backpressure();
        fill_queue();
        flush_pending();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/1ns

module tb_clkgen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset_o
);
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // reset drops on a falling edge, away from the sampling edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_o = 1'b0;
    end

endmodule
